// File: common/pi_bus_defs.svh
// slave window, sizes and timing of the PI slave; changing a size here needs a full recompile
`ifndef PI_BUS_DEFS_SVH
`define PI_BUS_DEFS_SVH

// bus field widths
`define PI_DATA_BITS    32              // data word
`define PI_ADDR_BITS    30              // word address
`define PI_OPC_BITS     4               // opcode field

// address window of this slave
`define PI_SLAVE_BASE   26'h0C0_0010    // upper address bits that hit this slave
`define PI_OFFSET_BITS  4               // word offset inside the window
`define PI_SLAVE_WORDS  16              // words in the register array

// device timing
`define PI_WBUF_DEPTH   4               // pending write entries
`define PI_DRAIN_CYCLES 6               // cycles between buffer pops
`define PI_RD_LATENCY   3               // active read cycles before data is ready

`define PI_OPC_SINGLE   4'h1            // single word transfer, the only one served

`endif

// File: common/pi_bus_pkg.sv
// bus types of the PI slave; ack keeps the bus encoding, RDM and RTR codes are not modelled
`include "pi_bus_defs.svh"

package pi_bus_pkg;

   // plain bus vectors
   typedef logic [`PI_DATA_BITS-1:0]   pi_data_t;     // read and write data
   typedef logic [`PI_ADDR_BITS-1:0]   pi_addr_t;     // word address
   typedef logic [`PI_OPC_BITS-1:0]    pi_opc_t;      // transfer opcode
   typedef logic [`PI_OFFSET_BITS-1:0] pi_offset_t;   // word inside the window

   // acknowledge code as seen on the bus
   typedef enum logic [2:0]
   {
      IDLE = 3'd0,                                    // no answer, also abort
      WAT  = 3'd1,                                    // slave busy
      ERR  = 3'd3,                                    // bad address or opcode
      RDY  = 3'd4                                     // transfer done
   } pi_ack_t;

   // transfer FSM states
   typedef enum logic [1:0]
   {
      ST_IDLE,                                        // wait for sel
      ST_ADDRESS,                                     // decode latched request
      ST_DATA_WAIT                                    // wait on device or tout
   } pi_slave_state_t;

   // master request, 35 bits
   typedef struct packed
   {
      pi_addr_t addr;                                 // word address
      pi_opc_t  opc;                                  // opcode
      logic     read;                                 // 1 read, 0 write
   } pi_req_t;

   // device status towards the FSM
   typedef struct packed
   {
      logic filled;                                   // write buffer full
      logic data_ready;                               // read data valid
      logic error;                                    // window or opcode miss
   } pi_dev_status_t;

   // one pending write, 36 bits
   typedef struct packed
   {
      pi_offset_t offset;                             // target word
      pi_data_t   data;                               // value to store
   } pi_wr_entry_t;

endpackage

// File: src/pi_slave_fsm.sv
// PI transfer FSM; single word transfers only, master must hold request until RDY, ERR or tout
`include "pi_bus_defs.svh"

module pi_slave_fsm
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       sel,        // slave select strobe
   input  pi_bus_pkg::pi_req_t        req,        // address, opcode, read level
   input  pi_bus_pkg::pi_data_t       din,        // write data from master
   input  logic                       tout,       // master gives up
   input  pi_bus_pkg::pi_dev_status_t status,     // device flags
   input  pi_bus_pkg::pi_data_t       rd_data,    // array word at latched offset
   output pi_bus_pkg::pi_ack_t        ack,        // registered acknowledge
   output pi_bus_pkg::pi_data_t       dout,       // registered read data
   output pi_bus_pkg::pi_req_t        lat_req,    // request held for the device
   output logic                       rd_active,  // read in progress
   output logic                       wr_push,    // one cycle buffer push
   output pi_bus_pkg::pi_wr_entry_t   wr_entry    // entry for the buffer
);
   import pi_bus_pkg::*;

   pi_slave_state_t state;                        // transfer state
   pi_data_t        lat_din;                      // write data held with request

   // buffer entry straight from the latched request
   assign wr_entry.offset = lat_req.addr[`PI_OFFSET_BITS-1:0];   // low address bits
   assign wr_entry.data   = lat_din;

   // request latch, taken when sel seen in idle
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && sel)
      begin
         lat_req <= req;                          // addr, opc, read
         lat_din <= din;                          // only used for writes
      end
   end

   // transfer machine
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= ST_IDLE;
         ack       <= IDLE;
         dout      <= '0;
         wr_push   <= 1'b0;
         rd_active <= 1'b0;
      end
      else
      begin
         wr_push <= 1'b0;                         // push is a pulse
         dout    <= '0;                           // zero outside read RDY
         case (state)
            ST_IDLE:
            begin
               ack <= IDLE;                       // ends RDY, ERR and abort
               if (sel)
               begin
                  state <= ST_ADDRESS;            // request latched above
               end
            end
            ST_ADDRESS:
            begin
               if (status.error)
               begin
                  ack   <= ERR;                   // one cycle, no data
                  state <= ST_IDLE;
               end
               else if (!lat_req.read && !status.filled)
               begin
                  wr_push <= 1'b1;                // buffer takes it next edge
                  ack     <= RDY;                 // 2 cycles after sel
                  state   <= ST_IDLE;
               end
               else
               begin
                  ack       <= WAT;               // read latency or full buffer
                  rd_active <= lat_req.read;      // start read counter
                  state     <= ST_DATA_WAIT;
               end
            end
            ST_DATA_WAIT:
            begin
               if (tout)
               begin
                  ack       <= IDLE;              // abort by master
                  rd_active <= 1'b0;
                  state     <= ST_IDLE;
               end
               else if (lat_req.read && status.data_ready)
               begin
                  ack       <= RDY;
                  dout      <= rd_data;           // drained array word
                  rd_active <= 1'b0;
                  state     <= ST_IDLE;
               end
               else if (!lat_req.read && !status.filled)
               begin
                  wr_push <= 1'b1;                // buffer has room again
                  ack     <= RDY;
                  state   <= ST_IDLE;
               end
               else
               begin
                  ack <= WAT;                     // keep the master waiting
               end
            end
            default:
            begin
               ack   <= IDLE;
               state <= ST_IDLE;                  // unused encoding
            end
         endcase
      end
   end

endmodule

// File: pi_device/pi_write_buffer.sv
// circular FIFO of pending writes; push when full and pop when empty are not allowed
`include "pi_bus_defs.svh"

module pi_write_buffer
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     push,        // from FSM, one cycle
   input  pi_bus_pkg::pi_wr_entry_t push_entry,  // offset and data
   input  logic                     pop,         // from drain timer
   output pi_bus_pkg::pi_wr_entry_t head,        // oldest entry
   output logic                     filled,      // no room left
   output logic                     empty        // nothing pending
);
   import pi_bus_pkg::*;

   localparam int unsigned DEPTH = `PI_WBUF_DEPTH;
   localparam int unsigned PTR_W = $clog2(DEPTH);
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   pi_wr_entry_t     mem [DEPTH];                // entry storage
   logic [PTR_W-1:0] wr_ptr;                     // next free slot
   logic [PTR_W-1:0] rd_ptr;                     // oldest slot
   logic [CNT_W-1:0] count;                      // entries held

   assign head   = mem[rd_ptr];                  // valid when not empty
   assign filled = (count == CNT_W'(DEPTH));
   assign empty  = (count == '0);

   // storage, no reset needed
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_entry;
      end
   end

   // pointers and fill count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            if (wr_ptr == PTR_W'(DEPTH - 1))
            begin
               wr_ptr <= '0;                     // wrap
            end
            else
            begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (pop)
         begin
            if (rd_ptr == PTR_W'(DEPTH - 1))
            begin
               rd_ptr <= '0;                     // wrap
            end
            else
            begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;      // push only
            2'b01:   count <= count - 1'b1;      // pop only
            default: count <= count;             // none or both
         endcase
      end
   end

endmodule

// File: pi_device/pi_device_core.sv
// memory device behind the FSM; reads wait for an empty write buffer, errors decode lat_req only
`include "pi_bus_defs.svh"

module pi_device_core
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  pi_bus_pkg::pi_req_t        lat_req,    // request held by the FSM
   input  logic                       rd_active,  // read in progress
   input  pi_bus_pkg::pi_wr_entry_t   head,       // oldest pending write
   input  logic                       filled,     // buffer full
   input  logic                       empty,      // buffer empty
   output logic                       pop,        // retire head this cycle
   output pi_bus_pkg::pi_dev_status_t status,     // flags to the FSM
   output pi_bus_pkg::pi_data_t       rd_data     // word at latched offset
);
   import pi_bus_pkg::*;

   localparam int unsigned DRAIN_W = $clog2(`PI_DRAIN_CYCLES);
   localparam int unsigned RD_W    = $clog2(`PI_RD_LATENCY + 1);

   pi_data_t           regs [`PI_SLAVE_WORDS];    // register array
   logic [DRAIN_W-1:0] drain_cnt;                 // cycles since last pop
   logic [RD_W-1:0]    rd_cnt;                    // active read cycles
   pi_offset_t         rd_offset;                 // word picked by the read
   logic               win_miss;                  // address outside window
   logic               opc_bad;                   // unsupported opcode

   // error decode on the latched request
   assign win_miss = (lat_req.addr[`PI_ADDR_BITS-1:`PI_OFFSET_BITS] != `PI_SLAVE_BASE);
   assign opc_bad  = (lat_req.opc != `PI_OPC_SINGLE);

   // drain pulse every PI_DRAIN_CYCLES while entries wait
   assign pop = !empty && (drain_cnt == DRAIN_W'(`PI_DRAIN_CYCLES - 1));

   assign rd_offset = lat_req.addr[`PI_OFFSET_BITS-1:0];
   assign rd_data   = regs[rd_offset];            // array already holds drained writes

   assign status.filled     = filled;
   assign status.data_ready = rd_active && (rd_cnt == RD_W'(`PI_RD_LATENCY)) && empty;
   assign status.error      = win_miss || opc_bad;

   // drain timer
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         drain_cnt <= '0;
      end
      else if (empty || pop)
      begin
         drain_cnt <= '0;                         // restart per entry
      end
      else
      begin
         drain_cnt <= drain_cnt + 1'b1;
      end
   end

   // read latency counter, saturates at PI_RD_LATENCY
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_cnt <= '0;
      end
      else if (!rd_active)
      begin
         rd_cnt <= '0;                            // restart between reads
      end
      else if (rd_cnt != RD_W'(`PI_RD_LATENCY))
      begin
         rd_cnt <= rd_cnt + 1'b1;
      end
   end

   // register array, written only by the drain
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `PI_SLAVE_WORDS; i++)
         begin
            regs[i] <= '0;                        // array reads zero after reset
         end
      end
      else if (pop)
      begin
         regs[head.offset] <= head.data;          // same edge as buffer pop
      end
   end

endmodule

// File: src/pi_slave_top.sv
// PI bus slave top; one slave on the bus, outputs read zero when inactive instead of tristate
module pi_slave_top
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 sel,    // slave select
   input  pi_bus_pkg::pi_req_t  req,    // address, opcode, read
   input  pi_bus_pkg::pi_data_t din,    // write data
   input  logic                 tout,   // master timeout
   output pi_bus_pkg::pi_ack_t  ack,    // acknowledge code
   output pi_bus_pkg::pi_data_t dout    // read data
);
   import pi_bus_pkg::*;

   pi_req_t        lat_req;             // FSM to core
   logic           rd_active;
   logic           wr_push;             // FSM to buffer
   pi_wr_entry_t   wr_entry;
   pi_wr_entry_t   head;                // buffer to core
   logic           filled;
   logic           empty;
   logic           pop;                 // core to buffer
   pi_dev_status_t status;              // core to FSM
   pi_data_t       rd_data;

   pi_slave_fsm u_fsm
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .sel       (sel),
      .req       (req),
      .din       (din),
      .tout      (tout),
      .status    (status),
      .rd_data   (rd_data),
      .ack       (ack),
      .dout      (dout),
      .lat_req   (lat_req),
      .rd_active (rd_active),
      .wr_push   (wr_push),
      .wr_entry  (wr_entry)
   );

   pi_write_buffer u_wbuf
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (wr_push),
      .push_entry (wr_entry),
      .pop        (pop),
      .head       (head),
      .filled     (filled),
      .empty      (empty)
   );

   pi_device_core u_core
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .lat_req   (lat_req),
      .rd_active (rd_active),
      .head      (head),
      .filled    (filled),
      .empty     (empty),
      .pop       (pop),
      .status    (status),
      .rd_data   (rd_data)
   );

endmodule

// File: test/pi_slave_assertions.sv
// protocol checks bound into pi_slave_fsm; they see only FSM ports, not the device internals
module pi_slave_assertions
(
   input logic                       clk,
   input logic                       rst_n,
   input pi_bus_pkg::pi_ack_t        ack,       // registered acknowledge
   input pi_bus_pkg::pi_data_t       dout,      // registered read data
   input logic                       wr_push,   // buffer push pulse
   input pi_bus_pkg::pi_dev_status_t status    // device flags
);
   import pi_bus_pkg::*;

   // reset drives the bus quiet
   ack_idle_in_reset: assert property (@(posedge clk) !rst_n |=> ack == IDLE)
      else $error("ack not IDLE while reset is held");

   // RDY lasts one cycle, FSM is back in idle after it
   rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack == RDY |=> ack == IDLE)
      else $error("ack RDY held longer than one cycle");

   // same for ERR
   err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack == ERR |=> ack == IDLE)
      else $error("ack ERR held longer than one cycle");

   // no push into a full buffer
   push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
      wr_push |-> !status.filled)
      else $error("write buffer pushed while filled");

   // dout only carries data in a RDY cycle
   dout_zero_idle: assert property (@(posedge clk) disable iff (!rst_n)
      ack != RDY |-> dout == '0)
      else $error("dout nonzero outside RDY");

endmodule

bind pi_slave_fsm pi_slave_assertions u_assert
(
   .clk     (clk),
   .rst_n   (rst_n),
   .ack     (ack),
   .dout    (dout),
   .wr_push (wr_push),
   .status  (status)
);

// File: test/tb_pi_slave.sv
// single master testbench; assumes one slave, a 16 word window and single word transfers only
`include "pi_bus_defs.svh"

module tb_pi_slave;
   import pi_bus_pkg::*;

   localparam int N_XFERS    = 61;                   // transfers issued by all tests
   localparam int XFER_LIMIT = 64;                   // cycles one transfer may take

   logic        clk;
   logic        rst_n;
   logic        sel;
   pi_req_t     req;
   pi_data_t    din;
   logic        tout;
   pi_ack_t     ack;
   pi_data_t    dout;

   pi_data_t    ref_mem [`PI_SLAVE_WORDS];           // expected array contents
   pi_data_t    exp_q [$];                           // read data owed to the compare process
   pi_data_t    exp_word;
   pi_offset_t  offs [10];
   integer      seed;
   logic [31:0] rnd;
   pi_ack_t     last_ack;                            // result of latest transfer
   pi_data_t    last_dout;
   int          last_cycles;                         // edges from drive to answer
   int          last_wats;
   int          wat_total;
   int          errors;
   int          test_start_errs;
   int          tests_run;
   int          tests_failed;
   int          reads_done;
   int          reads_checked;

   pi_slave_top DUT
   (
      .clk   (clk),
      .rst_n (rst_n),
      .sel   (sel),
      .req   (req),
      .din   (din),
      .tout  (tout),
      .ack   (ack),
      .dout  (dout)
   );

   always #4 clk = ~clk;                             // period 8

   function automatic pi_addr_t win_addr(input pi_offset_t off);
      return {`PI_SLAVE_BASE, off};                  // word inside this slave
   endfunction

   // RDY only for window hit and single opcode
   function automatic pi_ack_t expect_ack(input pi_addr_t addr, input pi_opc_t opc);
      if (addr[`PI_ADDR_BITS-1:`PI_OFFSET_BITS] == `PI_SLAVE_BASE && opc == `PI_OPC_SINGLE)
      begin
         return RDY;
      end
      return ERR;
   endfunction

   // reads wait for the drain, so latest accepted write wins
   function automatic pi_data_t ref_read(input pi_offset_t off);
      return ref_mem[off];
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("ERROR t=%0t %s", $time, msg);
      errors++;
   endtask

   // one bus transfer, entered and left at posedge+1
   task automatic run_transfer(input logic rd, input pi_addr_t addr, input pi_opc_t opc,
                               input pi_data_t data, input int tout_at);
      logic done;
      done        = 1'b0;
      last_cycles = 0;
      last_wats   = 0;
      last_ack    = IDLE;
      sel         = 1'b1;
      req.addr    = addr;
      req.opc     = opc;
      req.read    = rd;
      din         = data;
      while (!done)
      begin
         @(posedge clk);
         #1;
         last_cycles++;
         if (ack == WAT)
         begin
            last_wats++;
            if (tout_at > 0 && last_wats >= tout_at)
            begin
               tout = 1'b1;                          // give up on this transfer
            end
         end
         else if (ack == RDY || ack == ERR || (tout && ack == IDLE))
         begin
            done      = 1'b1;
            last_ack  = ack;
            last_dout = dout;
         end
         if (!done && last_cycles > XFER_LIMIT)
         begin
            report_problem("transfer got no acknowledge in time");
            done = 1'b1;
         end
      end
      sel  = 1'b0;                                   // next transfer may raise it again
      tout = 1'b0;
   endtask

   task automatic do_write(input pi_addr_t addr, input pi_opc_t opc, input pi_data_t data);
      pi_ack_t exp_ack;
      exp_ack = expect_ack(addr, opc);
      run_transfer(1'b0, addr, opc, data, 0);
      if (last_ack != exp_ack)
      begin
         report_mismatch("ack", 32'(exp_ack), 32'(last_ack));
      end
      if (last_ack == ERR && last_dout != '0)
      begin
         report_mismatch("dout", '0, last_dout);
      end
      if (exp_ack == RDY)
      begin
         ref_mem[addr[`PI_OFFSET_BITS-1:0]] = data;  // accepted writes land in order
      end
   endtask

   task automatic do_read(input pi_addr_t addr, input pi_opc_t opc, input int tout_at);
      pi_ack_t exp_ack;
      exp_ack = expect_ack(addr, opc);
      if (tout_at > 0)
      begin
         exp_ack = IDLE;                             // abort ends with IDLE
      end
      run_transfer(1'b1, addr, opc, '0, tout_at);
      if (last_ack != exp_ack)
      begin
         report_mismatch("ack", 32'(exp_ack), 32'(last_ack));
      end
      if (last_ack == ERR && last_dout != '0)
      begin
         report_mismatch("dout", '0, last_dout);
      end
      if (last_ack == RDY)
      begin
         exp_q.push_back(ref_read(addr[`PI_OFFSET_BITS-1:0]));
         reads_done++;
      end
   endtask

   // waits out the last compare, then realigns to posedge+1
   task automatic finish_test(input int num, input string name);
      int errs;
      @(negedge clk);
      #1;
      errs = errors - test_start_errs;
      tests_run++;
      if (errs > 0)
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", num, name, errs);
      end
      else
      begin
         $display("test %0d %s: ok", num, name);
      end
      test_start_errs = errors;
      @(posedge clk);
      #1;
   endtask

   // read data check at every RDY, mid cycle
   always @(negedge clk)
   begin
      if (rst_n && ack == RDY)
      begin
         if (exp_q.size() > 0)
         begin
            exp_word = exp_q.pop_front();
            reads_checked++;
            if (dout !== exp_word)
            begin
               report_mismatch("dout", exp_word, dout);
            end
         end
         else if (dout !== '0)
         begin
            report_mismatch("dout", '0, dout);       // write RDY carries no data
         end
      end
   end

   initial
   begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      sel             = 1'b0;
      req             = '0;
      din             = '0;
      tout            = 1'b0;
      seed            = 32'h98c5_b52c;
      errors          = 0;
      test_start_errs = 0;
      tests_run       = 0;
      tests_failed    = 0;
      reads_done      = 0;
      reads_checked   = 0;
      for (int i = 0; i < `PI_SLAVE_WORDS; i++)
      begin
         ref_mem[i] = '0;                            // array cleared by reset
      end
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < `PI_SLAVE_WORDS; i++)
      begin
         do_read(win_addr(pi_offset_t'(i)), `PI_OPC_SINGLE, 0);
      end
      rnd = $random(seed);
      do_write(win_addr(4'h5), `PI_OPC_SINGLE, rnd);
      if (last_cycles != 2)
      begin
         report_mismatch("write ack cycles", 32'd2, last_cycles);
      end
      finish_test(1, "reset contents and write latency");

      for (int i = 0; i < 6; i++)
      begin
         rnd     = $random(seed);
         offs[i] = rnd[`PI_OFFSET_BITS-1:0];
         rnd     = $random(seed);
         do_write(win_addr(offs[i]), `PI_OPC_SINGLE, rnd);
      end
      for (int i = 0; i < 6; i++)
      begin
         do_read(win_addr(offs[i]), `PI_OPC_SINGLE, 0);
      end
      rnd = $random(seed);
      do_write(win_addr(4'hA), `PI_OPC_SINGLE, rnd);
      do_read(win_addr(4'hA), `PI_OPC_SINGLE, 0);    // still buffered when issued
      finish_test(2, "random writes and read back");

      wat_total = 0;
      for (int i = 0; i < 10; i++)
      begin
         rnd = $random(seed);
         do_write(win_addr(pi_offset_t'(i)), `PI_OPC_SINGLE, rnd);
         wat_total += last_wats;
      end
      if (wat_total == 0)
      begin
         report_problem("burst of 10 writes never saw WAT");
      end
      for (int i = 0; i < 10; i++)
      begin
         do_read(win_addr(pi_offset_t'(i)), `PI_OPC_SINGLE, 0);
      end
      finish_test(3, "write burst with back-pressure");

      rnd = $random(seed);
      do_write({`PI_SLAVE_BASE ^ 26'h1, 4'h3}, `PI_OPC_SINGLE, rnd);
      do_write(win_addr(4'h3), 4'h2, rnd);
      do_read(win_addr(4'h3), 4'h2, 0);
      do_read(win_addr(4'h3), `PI_OPC_SINGLE, 0);    // array unchanged
      finish_test(4, "window and opcode errors");

      for (int i = 12; i < 16; i++)
      begin
         rnd = $random(seed);
         do_write(win_addr(pi_offset_t'(i)), `PI_OPC_SINGLE, rnd);
      end
      do_read(win_addr(4'hC), `PI_OPC_SINGLE, 1);    // tout on first WAT
      do_read(win_addr(4'hC), `PI_OPC_SINGLE, 0);
      finish_test(5, "read aborted by tout");

      if (exp_q.size() != 0 || reads_checked != reads_done)
      begin
         report_problem("not every read RDY reached the compare process");
      end
      $display("tests run %0d, tests failed %0d, checks failed %0d, reads compared %0d",
               tests_run, tests_failed, errors, reads_checked);
      if (errors == 0 && tests_failed == 0)
      begin
         $display("TESTBENCH PASSED");
      end
      else
      begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // run limit scaled by transfer count
   initial
   begin
      repeat (N_XFERS * XFER_LIMIT + 16) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not finish",
               N_XFERS * XFER_LIMIT + 16);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: pi_slave_top.f
+incdir+common
common/pi_bus_pkg.sv
src/pi_slave_fsm.sv
pi_device/pi_write_buffer.sv
pi_device/pi_device_core.sv
src/pi_slave_top.sv
test/pi_slave_assertions.sv
test/tb_pi_slave.sv

// File: run_sim.sh
#!/bin/sh
# build and run the PI slave testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pi_slave \
   -f pi_slave_top.f -o sim_pi_slave
./obj_dir/sim_pi_slave | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log
then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log
then
   echo "simulation ended without a result line"
   exit 1
fi
echo "simulation passed"
